// File: design/cache_memctrl_pkg.sv
// Fixed geometry of 20-bit tags, 64 sets and 4 words of 64 bits per line; ways set at the top
`default_nettype none

package cache_memctrl_pkg;

    // Directory and line geometry
    localparam int TagWidth     = 20;
    localparam int SetWidth     = 6;
    localparam int NumSets      = 1 << SetWidth;
    localparam int WordIdxWidth = 2;
    localparam int WordWidth    = 64;

    typedef logic [TagWidth-1:0]              tag_t;
    typedef logic [SetWidth-1:0]              set_t;
    typedef logic [WordIdxWidth-1:0]          word_idx_t;
    typedef logic [WordWidth-1:0]             word_t;
    typedef logic [WordWidth/8-1:0]           be_t;

    // Data RAM address is the set followed by the word index
    typedef logic [SetWidth+WordIdxWidth-1:0] data_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    typedef struct packed {
        set_t      set_idx;
        word_idx_t word_idx;
        tag_t      tag;
    } lookup_req_t;

    typedef struct packed {
        set_t      set_idx;
        word_idx_t word_idx;
        tag_t      tag;
        logic      dirty;
        word_t     data;
    } refill_req_t;

    typedef struct packed {
        set_t set_idx;
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_updt_req_t;

    // Hit write payload, the way comes from the previous lookup
    typedef struct packed {
        set_t      set_idx;
        word_idx_t word_idx;
        word_t     data;
        be_t       be;
    } write_req_t;

endpackage

`default_nettype wire

// File: design/sram_sp.sv
// Single-port RAM model with no memory reset; reads take one cycle and the output holds otherwise
`default_nettype none

module sram_sp #(
    parameter type payload_t = logic,
    parameter int  Depth     = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(Depth)-1:0] addr_i,
    input  payload_t                 wdata_i,
    input  payload_t                 wmask_i,
    output payload_t                 rdata_o
);

    localparam int Width = $bits(payload_t);

    logic [Width-1:0] mem_q [Depth];
    logic [Width-1:0] wdata_bits;
    logic [Width-1:0] wmask_bits;
    payload_t         rdata_q;

    assign wdata_bits = wdata_i;
    assign wmask_bits = wmask_i;

    // Bits outside the mask keep their old value
    always_ff @(posedge clk_i) begin
        if (cs_i && we_i) begin
            mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_bits) | (wdata_bits & wmask_bits);
        end
    end

    // Read port, holds while idle or writing
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (cs_i && !we_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/dir_access_ctrl.sv
// Requests are ignored until ready_o rises; at most one of lookup, refill and update per cycle
`default_nettype none

module dir_access_ctrl #(
    parameter int NumWays = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    input  logic                             lookup_i,
    input  cache_memctrl_pkg::lookup_req_t   lookup_req_i,

    input  logic                             refill_i,
    input  logic [NumWays-1:0]               refill_way_i,
    input  cache_memctrl_pkg::refill_req_t   refill_req_i,

    input  logic                             dir_updt_i,
    input  logic [NumWays-1:0]               dir_updt_way_i,
    input  cache_memctrl_pkg::dir_updt_req_t dir_updt_req_i,

    output logic [NumWays-1:0]               dir_cs_o,
    output logic [NumWays-1:0]               dir_we_o,
    output cache_memctrl_pkg::set_t          dir_addr_o,
    output cache_memctrl_pkg::dir_entry_t    dir_wentry_o,
    output logic                             ready_o
);

    import cache_memctrl_pkg::*;

    logic init_done_q;
    set_t init_set_q;

    // Init sequencer clears one set per cycle across all ways
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            init_set_q  <= '0;
        end else if (!init_done_q) begin
            init_set_q  <= init_set_q + 1'b1;
            init_done_q <= (init_set_q == set_t'(NumSets - 1));
        end
    end

    assign ready_o = init_done_q;

    // Port arbitration: init, lookup, refill, update
    always_comb begin
        dir_cs_o     = '0;
        dir_we_o     = '0;
        dir_addr_o   = '0;
        dir_wentry_o = '0;

        if (!init_done_q) begin
            dir_cs_o   = '1;
            dir_we_o   = '1;
            dir_addr_o = init_set_q;
        end else if (lookup_i) begin
            // All ways read for the tag compare
            dir_cs_o   = '1;
            dir_addr_o = lookup_req_i.set_idx;
        end else if (refill_i) begin
            dir_cs_o     = refill_way_i;
            dir_we_o     = refill_way_i;
            dir_addr_o   = refill_req_i.set_idx;
            dir_wentry_o = '{valid: 1'b1, dirty: refill_req_i.dirty, tag: refill_req_i.tag};
        end else if (dir_updt_i) begin
            dir_cs_o     = dir_updt_way_i;
            dir_we_o     = dir_updt_way_i;
            dir_addr_o   = dir_updt_req_i.set_idx;
            dir_wentry_o = '{
                valid: dir_updt_req_i.valid,
                dirty: dir_updt_req_i.dirty,
                tag:   dir_updt_req_i.tag
            };
        end
    end

endmodule

`default_nettype wire

// File: design/data_access_ctrl.sv
// Hit write relies on hit_way_i from the lookup one cycle earlier; no hit means no write
`default_nettype none

module data_access_ctrl #(
    parameter int NumWays = 4
) (
    input  logic                            lookup_i,
    input  cache_memctrl_pkg::lookup_req_t  lookup_req_i,

    input  logic                            refill_i,
    input  logic [NumWays-1:0]              refill_way_i,
    input  cache_memctrl_pkg::refill_req_t  refill_req_i,

    input  logic                            write_i,
    input  cache_memctrl_pkg::write_req_t   write_req_i,

    input  logic [NumWays-1:0]              hit_way_i,

    output logic [NumWays-1:0]              data_cs_o,
    output logic [NumWays-1:0]              data_we_o,
    output cache_memctrl_pkg::data_addr_t   data_addr_o,
    output cache_memctrl_pkg::word_t        data_wdata_o,
    output cache_memctrl_pkg::word_t        data_wmask_o
);

    import cache_memctrl_pkg::*;

    word_t be_mask;

    // Byte enables to bit mask
    always_comb begin
        for (int b = 0; b < $bits(be_t); b++) begin
            be_mask[8*b +: 8] = {8{write_req_i.be[b]}};
        end
    end

    always_comb begin
        data_cs_o    = '0;
        data_we_o    = '0;
        data_addr_o  = '0;
        data_wdata_o = '0;
        data_wmask_o = '0;

        if (lookup_i) begin
            // Same word read from every way
            data_cs_o   = '1;
            data_addr_o = {lookup_req_i.set_idx, lookup_req_i.word_idx};
        end else if (refill_i) begin
            data_cs_o    = refill_way_i;
            data_we_o    = refill_way_i;
            data_addr_o  = {refill_req_i.set_idx, refill_req_i.word_idx};
            data_wdata_o = refill_req_i.data;
            data_wmask_o = '1;
        end else if (write_i) begin
            data_cs_o    = hit_way_i;
            data_we_o    = hit_way_i;
            data_addr_o  = {write_req_i.set_idx, write_req_i.word_idx};
            data_wdata_o = write_req_i.data;
            data_wmask_o = be_mask;
        end
    end

endmodule

`default_nettype wire

// File: design/hit_resolve.sv
// Results are valid one cycle after a lookup and assume at most one way holds a given tag
`default_nettype none

module hit_resolve #(
    parameter int NumWays = 4
) (
    input  logic                                        clk_i,

    input  logic                                        lookup_i,
    input  cache_memctrl_pkg::tag_t                     lookup_tag_i,

    input  cache_memctrl_pkg::dir_entry_t [NumWays-1:0] dir_rentry_i,
    input  cache_memctrl_pkg::word_t      [NumWays-1:0] data_rword_i,

    output logic [NumWays-1:0]                          hit_way_o,
    output logic                                        hit_dirty_o,
    output cache_memctrl_pkg::word_t                    read_data_o
);

    import cache_memctrl_pkg::*;

    tag_t               lookup_tag_q;
    logic [NumWays-1:0] way_dirty;

    // Tag lines up with the RAM read data of the next cycle
    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            lookup_tag_q <= lookup_tag_i;
        end
    end

    for (genvar w = 0; w < NumWays; w++) begin : gen_way_cmp
        assign hit_way_o[w] = dir_rentry_i[w].valid && (dir_rentry_i[w].tag == lookup_tag_q);
        assign way_dirty[w] = dir_rentry_i[w].dirty;
    end

    assign hit_dirty_o = |(hit_way_o & way_dirty);

    // One-hot AND-OR select of the hit word
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < NumWays; w++) begin
            read_data_o = read_data_o | (data_rword_i[w] & {WordWidth{hit_way_o[w]}});
        end
    end

endmodule

`default_nettype wire

// File: design/cache_memctrl.sv
// Strobes must be mutually exclusive as documented and held low until ready_o; no back-pressure
`default_nettype none

module cache_memctrl #(
    parameter int NumWays = 4
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,

    input  logic                             lookup_i,
    input  cache_memctrl_pkg::lookup_req_t   lookup_req_i,

    input  logic                             refill_i,
    input  logic [NumWays-1:0]               refill_way_i,
    input  cache_memctrl_pkg::refill_req_t   refill_req_i,

    input  logic                             dir_updt_i,
    input  logic [NumWays-1:0]               dir_updt_way_i,
    input  cache_memctrl_pkg::dir_updt_req_t dir_updt_req_i,

    input  logic                             write_i,
    input  cache_memctrl_pkg::write_req_t    write_req_i,

    output logic                             ready_o,
    output logic [NumWays-1:0]               hit_way_o,
    output logic                             hit_dirty_o,
    output cache_memctrl_pkg::word_t         read_data_o
);

    import cache_memctrl_pkg::*;

    localparam int DataDepth = NumSets * (1 << WordIdxWidth);

    // Directory side
    logic [NumWays-1:0]       dir_cs;
    logic [NumWays-1:0]       dir_we;
    set_t                     dir_addr;
    dir_entry_t               dir_wentry;
    dir_entry_t [NumWays-1:0] dir_rentry;

    // Data side
    logic [NumWays-1:0]       data_cs;
    logic [NumWays-1:0]       data_we;
    data_addr_t               data_addr;
    word_t                    data_wdata;
    word_t                    data_wmask;
    word_t      [NumWays-1:0] data_rword;

    dir_access_ctrl #(
        .NumWays        (NumWays)
    ) u_dir_access_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_i       (lookup_i),
        .lookup_req_i   (lookup_req_i),
        .refill_i       (refill_i),
        .refill_way_i   (refill_way_i),
        .refill_req_i   (refill_req_i),
        .dir_updt_i     (dir_updt_i),
        .dir_updt_way_i (dir_updt_way_i),
        .dir_updt_req_i (dir_updt_req_i),
        .dir_cs_o       (dir_cs),
        .dir_we_o       (dir_we),
        .dir_addr_o     (dir_addr),
        .dir_wentry_o   (dir_wentry),
        .ready_o        (ready_o)
    );

    data_access_ctrl #(
        .NumWays      (NumWays)
    ) u_data_access_ctrl (
        .lookup_i     (lookup_i),
        .lookup_req_i (lookup_req_i),
        .refill_i     (refill_i),
        .refill_way_i (refill_way_i),
        .refill_req_i (refill_req_i),
        .write_i      (write_i),
        .write_req_i  (write_req_i),
        .hit_way_i    (hit_way_o),
        .data_cs_o    (data_cs),
        .data_we_o    (data_we),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_wmask_o (data_wmask)
    );

    // One directory RAM and one data RAM per way
    for (genvar w = 0; w < NumWays; w++) begin : gen_way
        sram_sp #(
            .payload_t (dir_entry_t),
            .Depth     (NumSets)
        ) u_dir_ram (
            .clk_i     (clk_i),
            .rst_ni    (rst_ni),
            .cs_i      (dir_cs[w]),
            .we_i      (dir_we[w]),
            .addr_i    (dir_addr),
            .wdata_i   (dir_wentry),
            .wmask_i   ('1),
            .rdata_o   (dir_rentry[w])
        );

        sram_sp #(
            .payload_t (word_t),
            .Depth     (DataDepth)
        ) u_data_ram (
            .clk_i     (clk_i),
            .rst_ni    (rst_ni),
            .cs_i      (data_cs[w]),
            .we_i      (data_we[w]),
            .addr_i    (data_addr),
            .wdata_i   (data_wdata),
            .wmask_i   (data_wmask),
            .rdata_o   (data_rword[w])
        );
    end

    hit_resolve #(
        .NumWays      (NumWays)
    ) u_hit_resolve (
        .clk_i        (clk_i),
        .lookup_i     (lookup_i),
        .lookup_tag_i (lookup_req_i.tag),
        .dir_rentry_i (dir_rentry),
        .data_rword_i (data_rword),
        .hit_way_o    (hit_way_o),
        .hit_dirty_o  (hit_dirty_o),
        .read_data_o  (read_data_o)
    );

endmodule

`default_nettype wire

// File: sim/cache_memctrl_assertions.sv
// Checks only the requester rules on the strobes; violations are also counted in fail_count
`default_nettype none

module cache_memctrl_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic lookup_i,
    input logic refill_i,
    input logic dir_updt_i,
    input logic write_i,
    input logic ready_i
);

    int unsigned fail_count = 0;

    // Lookup, refill and update share the directory port
    assert_dir_port_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({lookup_i, refill_i, dir_updt_i}))
    else begin
        $error("Lookup, refill and directory update strobes overlap");
        fail_count++;
    end

    // Lookup, refill and hit write share the data port
    assert_data_port_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({lookup_i, refill_i, write_i}))
    else begin
        $error("Lookup, refill and hit write strobes overlap");
        fail_count++;
    end

    assert_no_strobe_before_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_i |-> !(lookup_i || refill_i || dir_updt_i || write_i))
    else begin
        $error("A strobe was raised while ready was low");
        fail_count++;
    end

    // Hit write uses the hit way of the lookup one cycle earlier
    assert_write_after_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        write_i |-> $past(lookup_i))
    else begin
        $error("Hit write without a lookup in the cycle before");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: sim/tb_cache_memctrl.sv
// Assumes NumWays 4; the low two tag bits follow the way, so no set ever holds a tag twice
`default_nettype none

module tb_cache_memctrl;

    import cache_memctrl_pkg::*;

    localparam int NumWays      = 4;
    localparam int WordsPerLine = 1 << WordIdxWidth;
    localparam int NumOps       = 400;
    localparam int MaxCycles    = NumSets + 20 + 4 * NumOps;

    logic               clk_i;
    logic               rst_ni;
    logic               lookup_i;
    lookup_req_t        lookup_req_i;
    logic               refill_i;
    logic [NumWays-1:0] refill_way_i;
    refill_req_t        refill_req_i;
    logic               dir_updt_i;
    logic [NumWays-1:0] dir_updt_way_i;
    dir_updt_req_t      dir_updt_req_i;
    logic               write_i;
    write_req_t         write_req_i;
    logic               ready_o;
    logic [NumWays-1:0] hit_way_o;
    logic               hit_dirty_o;
    word_t              read_data_o;

    integer seed;

    // Reference directory and data, indexed by set, way and word
    logic  model_valid [NumSets][NumWays];
    logic  model_dirty [NumSets][NumWays];
    tag_t  model_tag   [NumSets][NumWays];
    word_t model_data  [NumSets][NumWays][WordsPerLine];

    cache_memctrl #(
        .NumWays        (NumWays)
    ) u_cache_memctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_i       (lookup_i),
        .lookup_req_i   (lookup_req_i),
        .refill_i       (refill_i),
        .refill_way_i   (refill_way_i),
        .refill_req_i   (refill_req_i),
        .dir_updt_i     (dir_updt_i),
        .dir_updt_way_i (dir_updt_way_i),
        .dir_updt_req_i (dir_updt_req_i),
        .write_i        (write_i),
        .write_req_i    (write_req_i),
        .ready_o        (ready_o),
        .hit_way_o      (hit_way_o),
        .hit_dirty_o    (hit_dirty_o),
        .read_data_o    (read_data_o)
    );

    bind cache_memctrl cache_memctrl_assertions u_cache_memctrl_assertions (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .lookup_i   (lookup_i),
        .refill_i   (refill_i),
        .dir_updt_i (dir_updt_i),
        .write_i    (write_i),
        .ready_i    (ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MaxCycles) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
        abort_run();
    end

    // Stop at the first violation of the requester rules
    initial begin : assertion_monitor
        wait (u_cache_memctrl.u_cache_memctrl_assertions.fail_count != 0);
        $display("A bound assertion on the request strobes failed");
        abort_run();
    end

    task automatic check_way(input string name, input logic [NumWays-1:0] got,
                             input logic [NumWays-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic tag_t unique_tag(input int way);
        tag_t t;
        t      = tag_t'(rand32());
        t[1:0] = way[1:0];
        return t;
    endfunction

    function automatic logic tag_present(input set_t s, input tag_t t);
        logic found;
        found = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            found = found | (model_valid[s][w] && model_tag[s][w] == t);
        end
        return found;
    endfunction

    // Inputs change 2 units after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic lookup_and_check(input set_t s, input word_idx_t wi, input tag_t t,
                                    output logic [NumWays-1:0] exp_hit);
        logic  exp_dirty;
        word_t exp_word;
        lookup_i     = 1'b1;
        lookup_req_i = '{set_idx: s, word_idx: wi, tag: t};
        next_cycle();
        lookup_i  = 1'b0;
        exp_hit   = '0;
        exp_dirty = 1'b0;
        exp_word  = '0;
        for (int w = 0; w < NumWays; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                exp_hit[w] = 1'b1;
                exp_dirty  = exp_dirty | model_dirty[s][w];
                exp_word   = model_data[s][w][wi];
            end
        end
        check_way("hit_way_o", hit_way_o, exp_hit);
        check_bit("hit_dirty_o", hit_dirty_o, exp_dirty);
        if (exp_hit != '0) begin
            check_word("read_data_o", read_data_o, exp_word);
        end
    endtask

    task automatic refill_line(input int way, input set_t s, input word_idx_t wi,
                               input tag_t t, input logic d, input word_t data);
        refill_i          = 1'b1;
        refill_way_i      = '0;
        refill_way_i[way] = 1'b1;
        refill_req_i      = '{set_idx: s, word_idx: wi, tag: t, dirty: d, data: data};
        next_cycle();
        refill_i              = 1'b0;
        model_valid[s][way]   = 1'b1;
        model_dirty[s][way]   = d;
        model_tag[s][way]     = t;
        model_data[s][way][wi] = data;
    endtask

    task automatic update_dir(input logic [NumWays-1:0] ways, input set_t s,
                              input logic v, input logic d, input tag_t t);
        dir_updt_i     = 1'b1;
        dir_updt_way_i = ways;
        dir_updt_req_i = '{set_idx: s, valid: v, dirty: d, tag: t};
        next_cycle();
        dir_updt_i = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            if (ways[w]) begin
                model_valid[s][w] = v;
                model_dirty[s][w] = d;
                model_tag[s][w]   = t;
            end
        end
    endtask

    // Only enabled bytes of the hit way change
    task automatic write_hit(input logic [NumWays-1:0] hit, input set_t s,
                             input word_idx_t wi, input word_t data, input be_t be);
        write_i     = 1'b1;
        write_req_i = '{set_idx: s, word_idx: wi, data: data, be: be};
        next_cycle();
        write_i = 1'b0;
        for (int w = 0; w < NumWays; w++) begin
            for (int b = 0; b < $bits(be_t); b++) begin
                if (hit[w] && be[b]) begin
                    model_data[s][w][wi][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    initial begin : stimulus
        set_t               s;
        word_idx_t          wi;
        tag_t               t;
        logic [NumWays-1:0] ways;
        logic [NumWays-1:0] hit;
        int                 way;
        int                 op;
        seed           = 32'he414;
        rst_ni         = 1'b0;
        lookup_i       = 1'b0;
        lookup_req_i   = '0;
        refill_i       = 1'b0;
        refill_way_i   = '0;
        refill_req_i   = '0;
        dir_updt_i     = 1'b0;
        dir_updt_way_i = '0;
        dir_updt_req_i = '0;
        write_i        = 1'b0;
        write_req_i    = '0;
        for (int i = 0; i < NumSets; i++) begin
            for (int w = 0; w < NumWays; w++) begin
                model_valid[i][w] = 1'b0;
                model_dirty[i][w] = 1'b0;
                model_tag[i][w]   = '0;
            end
        end

        repeat (8) begin
            next_cycle();
            check_bit("ready_o", ready_o, 1'b0);
        end
        rst_ni = 1'b1;
        repeat (NumSets - 1) next_cycle();
        check_bit("ready_o", ready_o, 1'b0);
        next_cycle();
        check_bit("ready_o", ready_o, 1'b1);

        // Cleared directory misses everywhere
        repeat (4) begin
            lookup_and_check(set_t'(rand32()), word_idx_t'(rand32()),
                             tag_t'(rand32()), hit);
            check_way("hit_way_o after init", hit_way_o, '0);
        end

        for (int i = 0; i < NumOps; i++) begin
            op  = rand32() % 4;
            s   = set_t'(rand32());
            wi  = word_idx_t'(rand32());
            way = rand32() % NumWays;
            case (op)
                0: begin
                    t = unique_tag(way);
                    refill_line(way, s, wi, t, 1'(rand32()), {rand32(), rand32()});
                    lookup_and_check(s, wi, t, hit);
                end
                1: begin
                    t = model_tag[s][way];
                    lookup_and_check(s, wi, t, hit);
                    if (1'(rand32())) begin
                        write_hit(hit, s, wi, {rand32(), rand32()}, be_t'(rand32()));
                        lookup_and_check(s, wi, t, hit);
                    end
                end
                2: begin
                    // Tag absent from every way, the write after it must not land
                    do begin
                        t = tag_t'(rand32());
                    end while (tag_present(s, t));
                    lookup_and_check(s, wi, t, hit);
                    write_hit(hit, s, wi, {rand32(), rand32()}, be_t'(rand32()));
                end
                default: begin
                    // Old tag, with its low bits tied to the way it may be revalidated in
                    t      = model_tag[s][way];
                    t[1:0] = way[1:0];
                    if (1'(rand32())) begin
                        ways      = '0;
                        ways[way] = 1'b1;
                        update_dir(ways, s, 1'(rand32()), 1'(rand32()),
                                   1'(rand32()) ? unique_tag(way) : t);
                    end else begin
                        // Several ways share one entry only when cleared
                        ways = NumWays'(rand32());
                        update_dir(ways, s, 1'b0, 1'(rand32()), tag_t'(rand32()));
                    end
                    lookup_and_check(s, wi, t, hit);
                end
            endcase
        end

        if (u_cache_memctrl.u_cache_memctrl_assertions.fail_count != 0) begin
            $display("Bound assertions reported %0d violations",
                     u_cache_memctrl.u_cache_memctrl_assertions.fail_count);
            abort_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: cache_memctrl.f
design/cache_memctrl_pkg.sv
design/sram_sp.sv
design/dir_access_ctrl.sv
design/data_access_ctrl.sv
design/hit_resolve.sv
design/cache_memctrl.sv
sim/cache_memctrl_assertions.sv
sim/tb_cache_memctrl.sv

// File: Bender.yml
package:
  name: cache_memctrl

sources:
  - design/cache_memctrl_pkg.sv
  - design/sram_sp.sv
  - design/dir_access_ctrl.sv
  - design/data_access_ctrl.sv
  - design/hit_resolve.sv
  - design/cache_memctrl.sv
  - target: simulation
    files:
      - sim/cache_memctrl_assertions.sv
      - sim/tb_cache_memctrl.sv
